/* logic/ex_pkg.sv */
package ex_pkg;

    localparam int data_w     = 32;
    localparam int reg_addr_w = 5;
    localparam int div_steps  = 32;

    // one value per supported instruction
    typedef enum logic [5:0] {
        op_add, op_addu, op_sub, op_subu,
        op_slt, op_sltu,
        op_and, op_or, op_xor, op_nor,
        op_sll, op_srl, op_sra, op_sllv, op_srlv, op_srav,
        op_addi, op_addiu, op_slti, op_sltiu,
        op_andi, op_ori, op_xori, op_lui,
        op_mult, op_multu, op_div, op_divu,
        op_mthi, op_mtlo, op_mfhi, op_mflo,
        op_illegal
    } alu_op_e;

    typedef enum logic {
        dec_idle,
        dec_busy
    } dec_state_e;

    // major opcodes
    localparam logic [5:0] opcode_special = 6'h00;
    localparam logic [5:0] opc_addi       = 6'h08;
    localparam logic [5:0] opc_addiu      = 6'h09;
    localparam logic [5:0] opc_slti       = 6'h0a;
    localparam logic [5:0] opc_sltiu      = 6'h0b;
    localparam logic [5:0] opc_andi       = 6'h0c;
    localparam logic [5:0] opc_ori        = 6'h0d;
    localparam logic [5:0] opc_xori       = 6'h0e;
    localparam logic [5:0] opc_lui        = 6'h0f;

    // funct field of special
    localparam logic [5:0] funct_sll   = 6'h00;
    localparam logic [5:0] funct_srl   = 6'h02;
    localparam logic [5:0] funct_sra   = 6'h03;
    localparam logic [5:0] funct_sllv  = 6'h04;
    localparam logic [5:0] funct_srlv  = 6'h06;
    localparam logic [5:0] funct_srav  = 6'h07;
    localparam logic [5:0] funct_mfhi  = 6'h10;
    localparam logic [5:0] funct_mthi  = 6'h11;
    localparam logic [5:0] funct_mflo  = 6'h12;
    localparam logic [5:0] funct_mtlo  = 6'h13;
    localparam logic [5:0] funct_mult  = 6'h18;
    localparam logic [5:0] funct_multu = 6'h19;
    localparam logic [5:0] funct_div   = 6'h1a;
    localparam logic [5:0] funct_divu  = 6'h1b;
    localparam logic [5:0] funct_add   = 6'h20;
    localparam logic [5:0] funct_addu  = 6'h21;
    localparam logic [5:0] funct_sub   = 6'h22;
    localparam logic [5:0] funct_subu  = 6'h23;
    localparam logic [5:0] funct_and   = 6'h24;
    localparam logic [5:0] funct_or    = 6'h25;
    localparam logic [5:0] funct_xor   = 6'h26;
    localparam logic [5:0] funct_nor   = 6'h27;
    localparam logic [5:0] funct_slt   = 6'h2a;
    localparam logic [5:0] funct_sltu  = 6'h2b;

endpackage

/* logic/ex_op_if.sv */
interface ex_op_if;

    logic                            valid;
    ex_pkg::alu_op_e                 op;
    logic [ex_pkg::data_w-1:0]       a;
    logic [ex_pkg::data_w-1:0]       b;
    logic [4:0]                      shamt;
    logic [ex_pkg::reg_addr_w-1:0]   dest;
    logic                            wr;

    modport dec_mp (
        output valid, op, a, b, shamt, dest, wr
    );

    modport exe_mp (
        input valid, op, a, b, shamt, dest, wr
    );

endinterface

/* logic/ex_res_if.sv */
interface ex_res_if;

    logic                            valid;
    logic [ex_pkg::data_w-1:0]       data;
    logic [ex_pkg::reg_addr_w-1:0]   dest;
    logic                            wr;
    logic                            overflow;
    logic                            hi_we;
    logic                            lo_we;
    logic [ex_pkg::data_w-1:0]       hi;
    logic [ex_pkg::data_w-1:0]       lo;
    logic                            read_hi;
    logic                            read_lo;

    modport exe_mp (
        output valid, data, dest, wr, overflow, hi_we, lo_we, hi, lo, read_hi, read_lo
    );

    modport wb_mp (
        input valid, data, dest, wr, overflow, hi_we, lo_we, hi, lo, read_hi, read_lo
    );

endinterface

/* logic/ex_divider.sv */
module ex_divider (
    input  logic                       clk,
    input  logic                       rst_i,
    input  logic                       start_i,
    input  logic                       signed_i,
    input  logic [ex_pkg::data_w-1:0]  dividend_i,
    input  logic [ex_pkg::data_w-1:0]  divisor_i,
    output logic                       busy_o,
    output logic                       done_o,
    output logic [ex_pkg::data_w-1:0]  quotient_o,
    output logic [ex_pkg::data_w-1:0]  remainder_o
);

    logic [ex_pkg::data_w-1:0]    quo;
    logic [ex_pkg::data_w-1:0]    rem;
    logic [ex_pkg::data_w-1:0]    dvs;
    logic                         q_neg;
    logic                         r_neg;
    logic [$clog2(ex_pkg::div_steps)-1:0] step_cnt;
    logic [ex_pkg::data_w:0]      shifted;
    logic [ex_pkg::data_w:0]      trial;

    // next partial remainder and trial subtraction
    assign shifted = {rem, quo[ex_pkg::data_w-1]};
    assign trial   = shifted - {1'b0, dvs};

    always_ff @(posedge clk) begin
        if (rst_i) begin
            busy_o <= 1'b0;
            done_o <= 1'b0;
        end else begin
            done_o <= busy_o && (int'(step_cnt) == ex_pkg::div_steps - 1);
            if (start_i) begin
                busy_o <= 1'b1;
            end else if (busy_o && int'(step_cnt) == ex_pkg::div_steps - 1) begin
                busy_o <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start_i) begin
            quo      <= (signed_i && dividend_i[31]) ? -dividend_i : dividend_i;
            dvs      <= (signed_i && divisor_i[31]) ? -divisor_i : divisor_i;
            rem      <= '0;
            step_cnt <= '0;
            q_neg    <= signed_i && (dividend_i[31] ^ divisor_i[31]);
            r_neg    <= signed_i && dividend_i[31];
        end else if (busy_o) begin
            step_cnt <= step_cnt + 1'b1;
            if (!trial[ex_pkg::data_w]) begin
                rem <= trial[ex_pkg::data_w-1:0];
                quo <= {quo[ex_pkg::data_w-2:0], 1'b1};
            end else begin
                rem <= shifted[ex_pkg::data_w-1:0];
                quo <= {quo[ex_pkg::data_w-2:0], 1'b0};
            end
        end
    end

    // remainder follows the dividend sign
    assign quotient_o  = q_neg ? -quo : quo;
    assign remainder_o = r_neg ? -rem : rem;

endmodule

/* logic/ex_decode.sv */
module ex_decode (
    input  logic                       clk,
    input  logic                       rst_i,
    input  logic                       req_i,
    input  logic [ex_pkg::data_w-1:0]  instr_i,
    input  logic [ex_pkg::data_w-1:0]  rs_data_i,
    input  logic [ex_pkg::data_w-1:0]  rt_data_i,
    input  logic                       release_i,
    ex_op_if.dec_mp                    op
);

    ex_pkg::dec_state_e               state;
    ex_pkg::alu_op_e                  dec_op;
    logic [ex_pkg::data_w-1:0]        dec_b;
    logic [ex_pkg::reg_addr_w-1:0]    dec_dest;
    logic [5:0]                       opcode;
    logic [5:0]                       funct;
    logic [15:0]                      imm;
    logic                             accept;

    assign opcode = instr_i[31:26];
    assign funct  = instr_i[5:0];
    assign imm    = instr_i[15:0];
    assign accept = req_i && (state == ex_pkg::dec_idle);

    always_comb begin
        dec_op   = ex_pkg::op_illegal;
        dec_b    = rt_data_i;
        dec_dest = instr_i[15:11];
        if (opcode == ex_pkg::opcode_special) begin
            case (funct)
                ex_pkg::funct_add:   dec_op = ex_pkg::op_add;
                ex_pkg::funct_addu:  dec_op = ex_pkg::op_addu;
                ex_pkg::funct_sub:   dec_op = ex_pkg::op_sub;
                ex_pkg::funct_subu:  dec_op = ex_pkg::op_subu;
                ex_pkg::funct_slt:   dec_op = ex_pkg::op_slt;
                ex_pkg::funct_sltu:  dec_op = ex_pkg::op_sltu;
                ex_pkg::funct_and:   dec_op = ex_pkg::op_and;
                ex_pkg::funct_or:    dec_op = ex_pkg::op_or;
                ex_pkg::funct_xor:   dec_op = ex_pkg::op_xor;
                ex_pkg::funct_nor:   dec_op = ex_pkg::op_nor;
                ex_pkg::funct_sll:   dec_op = ex_pkg::op_sll;
                ex_pkg::funct_srl:   dec_op = ex_pkg::op_srl;
                ex_pkg::funct_sra:   dec_op = ex_pkg::op_sra;
                ex_pkg::funct_sllv:  dec_op = ex_pkg::op_sllv;
                ex_pkg::funct_srlv:  dec_op = ex_pkg::op_srlv;
                ex_pkg::funct_srav:  dec_op = ex_pkg::op_srav;
                ex_pkg::funct_mult:  dec_op = ex_pkg::op_mult;
                ex_pkg::funct_multu: dec_op = ex_pkg::op_multu;
                ex_pkg::funct_div:   dec_op = ex_pkg::op_div;
                ex_pkg::funct_divu:  dec_op = ex_pkg::op_divu;
                ex_pkg::funct_mthi:  dec_op = ex_pkg::op_mthi;
                ex_pkg::funct_mtlo:  dec_op = ex_pkg::op_mtlo;
                ex_pkg::funct_mfhi:  dec_op = ex_pkg::op_mfhi;
                ex_pkg::funct_mflo:  dec_op = ex_pkg::op_mflo;
                default:             dec_op = ex_pkg::op_illegal;
            endcase
        end else begin
            // I-type writes rt
            dec_dest = instr_i[20:16];
            dec_b    = {{16{imm[15]}}, imm};
            case (opcode)
                ex_pkg::opc_addi:  dec_op = ex_pkg::op_addi;
                ex_pkg::opc_addiu: dec_op = ex_pkg::op_addiu;
                ex_pkg::opc_slti:  dec_op = ex_pkg::op_slti;
                ex_pkg::opc_sltiu: dec_op = ex_pkg::op_sltiu;
                ex_pkg::opc_andi: begin
                    dec_op = ex_pkg::op_andi;
                    dec_b  = {16'h0000, imm};
                end
                ex_pkg::opc_ori: begin
                    dec_op = ex_pkg::op_ori;
                    dec_b  = {16'h0000, imm};
                end
                ex_pkg::opc_xori: begin
                    dec_op = ex_pkg::op_xori;
                    dec_b  = {16'h0000, imm};
                end
                ex_pkg::opc_lui: begin
                    dec_op = ex_pkg::op_lui;
                    dec_b  = {imm, 16'h0000};
                end
                default: dec_op = ex_pkg::op_illegal;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state    <= ex_pkg::dec_idle;
            op.valid <= 1'b0;
        end else begin
            op.valid <= accept;
            if (accept) begin
                state <= ex_pkg::dec_busy;
            end else if (release_i) begin
                state <= ex_pkg::dec_idle;
            end
        end
    end

    // operands held until the next accepted request
    always_ff @(posedge clk) begin
        if (accept) begin
            op.op    <= dec_op;
            op.a     <= rs_data_i;
            op.b     <= dec_b;
            op.shamt <= instr_i[10:6];
            op.dest  <= dec_dest;
            op.wr    <= !(dec_op inside {ex_pkg::op_mult, ex_pkg::op_multu, ex_pkg::op_div,
                                         ex_pkg::op_divu, ex_pkg::op_mthi, ex_pkg::op_mtlo,
                                         ex_pkg::op_illegal});
        end
    end

endmodule

/* logic/ex_execute.sv */
module ex_execute (
    input  logic    clk,
    input  logic    rst_i,
    ex_op_if.exe_mp op,
    ex_res_if.exe_mp res
);

    logic [ex_pkg::data_w-1:0]    sum;
    logic [ex_pkg::data_w-1:0]    diff;
    logic [ex_pkg::data_w-1:0]    alu_res;
    logic [4:0]                   sh_amt;
    logic                         ovf;
    logic                         sign_mul;
    logic [2*ex_pkg::data_w-1:0]  mul_a;
    logic [2*ex_pkg::data_w-1:0]  mul_b;
    logic [2*ex_pkg::data_w-1:0]  prod;
    logic                         is_div;
    logic                         div_start;
    logic                         div_busy;
    logic                         div_done;
    logic [ex_pkg::data_w-1:0]    div_quo;
    logic [ex_pkg::data_w-1:0]    div_rem;

    assign sum  = op.a + op.b;
    assign diff = op.a - op.b;

    // variable shifts take rs[4:0]
    assign sh_amt = (op.op inside {ex_pkg::op_sllv, ex_pkg::op_srlv, ex_pkg::op_srav}) ?
                    op.a[4:0] : op.shamt;

    always_comb begin
        alu_res = '0;
        ovf     = 1'b0;
        case (op.op)
            ex_pkg::op_add, ex_pkg::op_addi: begin
                alu_res = sum;
                ovf     = (op.a[31] == op.b[31]) && (sum[31] != op.a[31]);
            end
            ex_pkg::op_addu, ex_pkg::op_addiu: alu_res = sum;
            ex_pkg::op_sub: begin
                alu_res = diff;
                ovf     = (op.a[31] != op.b[31]) && (diff[31] != op.a[31]);
            end
            ex_pkg::op_subu: alu_res = diff;
            ex_pkg::op_slt, ex_pkg::op_slti: alu_res = {31'b0, $signed(op.a) < $signed(op.b)};
            ex_pkg::op_sltu, ex_pkg::op_sltiu: alu_res = {31'b0, op.a < op.b};
            ex_pkg::op_and, ex_pkg::op_andi: alu_res = op.a & op.b;
            ex_pkg::op_or, ex_pkg::op_ori: alu_res = op.a | op.b;
            ex_pkg::op_xor, ex_pkg::op_xori: alu_res = op.a ^ op.b;
            ex_pkg::op_nor: alu_res = ~(op.a | op.b);
            ex_pkg::op_lui: alu_res = op.b;
            ex_pkg::op_sll, ex_pkg::op_sllv: alu_res = op.b << sh_amt;
            ex_pkg::op_srl, ex_pkg::op_srlv: alu_res = op.b >> sh_amt;
            ex_pkg::op_sra, ex_pkg::op_srav: alu_res = $signed(op.b) >>> sh_amt;
            default: alu_res = '0;
        endcase
    end

    // one 64-bit multiplier, sign handled by the extension
    assign sign_mul = (op.op == ex_pkg::op_mult);
    assign mul_a    = {{ex_pkg::data_w{sign_mul & op.a[31]}}, op.a};
    assign mul_b    = {{ex_pkg::data_w{sign_mul & op.b[31]}}, op.b};
    assign prod     = mul_a * mul_b;

    assign is_div    = op.op inside {ex_pkg::op_div, ex_pkg::op_divu};
    assign div_start = op.valid && is_div && !div_busy;

    ex_divider u_ex_divider (
        .clk         (clk),
        .rst_i       (rst_i),
        .start_i     (div_start),
        .signed_i    (op.op == ex_pkg::op_div),
        .dividend_i  (op.a),
        .divisor_i   (op.b),
        .busy_o      (div_busy),
        .done_o      (div_done),
        .quotient_o  (div_quo),
        .remainder_o (div_rem)
    );

    always_ff @(posedge clk) begin
        if (rst_i) begin
            res.valid <= 1'b0;
        end else begin
            res.valid <= (op.valid && !is_div) || div_done;
        end
    end

    always_ff @(posedge clk) begin
        if (div_done) begin
            res.data     <= '0;
            res.wr       <= 1'b0;
            res.overflow <= 1'b0;
            res.hi_we    <= 1'b1;
            res.lo_we    <= 1'b1;
            res.hi       <= div_rem;
            res.lo       <= div_quo;
            res.read_hi  <= 1'b0;
            res.read_lo  <= 1'b0;
        end else if (op.valid) begin
            res.data     <= alu_res;
            res.dest     <= op.dest;
            // overflow suppresses the register write
            res.wr       <= op.wr && !ovf;
            res.overflow <= ovf;
            res.hi_we    <= op.op inside {ex_pkg::op_mult, ex_pkg::op_multu, ex_pkg::op_mthi};
            res.lo_we    <= op.op inside {ex_pkg::op_mult, ex_pkg::op_multu, ex_pkg::op_mtlo};
            res.hi       <= (op.op == ex_pkg::op_mthi) ? op.a : prod[63:32];
            res.lo       <= (op.op == ex_pkg::op_mtlo) ? op.a : prod[31:0];
            res.read_hi  <= (op.op == ex_pkg::op_mfhi);
            res.read_lo  <= (op.op == ex_pkg::op_mflo);
        end
    end

endmodule

/* logic/ex_writeback.sv */
module ex_writeback (
    input  logic                           clk,
    input  logic                           rst_i,
    input  logic                           req_i,
    ex_res_if.wb_mp                        res,
    output logic                           ack_o,
    output logic                           wr_en_o,
    output logic [ex_pkg::reg_addr_w-1:0]  wr_addr_o,
    output logic [ex_pkg::data_w-1:0]      wr_data_o,
    output logic                           overflow_o,
    output logic                           release_o
);

    logic [ex_pkg::data_w-1:0] hi_q;
    logic [ex_pkg::data_w-1:0] lo_q;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            hi_q <= '0;
            lo_q <= '0;
        end else if (res.valid) begin
            if (res.hi_we) begin
                hi_q <= res.hi;
            end
            if (res.lo_we) begin
                lo_q <= res.lo;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            ack_o      <= 1'b0;
            wr_en_o    <= 1'b0;
            overflow_o <= 1'b0;
            release_o  <= 1'b0;
        end else begin
            release_o <= 1'b0;
            if (res.valid) begin
                ack_o      <= 1'b1;
                wr_en_o    <= res.wr;
                overflow_o <= res.overflow;
            end else if (ack_o && !req_i) begin
                // request dropped, close the handshake
                ack_o     <= 1'b0;
                release_o <= 1'b1;
            end
        end
    end

    // mfhi and mflo read the stored pair
    always_ff @(posedge clk) begin
        if (res.valid) begin
            wr_addr_o <= res.dest;
            wr_data_o <= res.read_hi ? hi_q : (res.read_lo ? lo_q : res.data);
        end
    end

endmodule

/* logic/ex_stage_top.sv */
module ex_stage_top (
    input  logic                           clk,
    input  logic                           rst_i,
    input  logic                           req_i,
    input  logic [ex_pkg::data_w-1:0]      instr_i,
    input  logic [ex_pkg::data_w-1:0]      rs_data_i,
    input  logic [ex_pkg::data_w-1:0]      rt_data_i,
    output logic                           ack_o,
    output logic                           wr_en_o,
    output logic [ex_pkg::reg_addr_w-1:0]  wr_addr_o,
    output logic [ex_pkg::data_w-1:0]      wr_data_o,
    output logic                           overflow_o
);

    logic wb_release;

    ex_op_if  op_if ();
    ex_res_if res_if ();

    ex_decode u_ex_decode (
        .clk       (clk),
        .rst_i     (rst_i),
        .req_i     (req_i),
        .instr_i   (instr_i),
        .rs_data_i (rs_data_i),
        .rt_data_i (rt_data_i),
        .release_i (wb_release),
        .op        (op_if.dec_mp)
    );

    ex_execute u_ex_execute (
        .clk   (clk),
        .rst_i (rst_i),
        .op    (op_if.exe_mp),
        .res   (res_if.exe_mp)
    );

    ex_writeback u_ex_writeback (
        .clk        (clk),
        .rst_i      (rst_i),
        .req_i      (req_i),
        .res        (res_if.wb_mp),
        .ack_o      (ack_o),
        .wr_en_o    (wr_en_o),
        .wr_addr_o  (wr_addr_o),
        .wr_data_o  (wr_data_o),
        .overflow_o (overflow_o),
        .release_o  (wb_release)
    );

endmodule

/* verif/ex_stage_properties.sv */
module ex_stage_properties (
    input logic                           clk,
    input logic                           rst_i,
    input logic                           req_i,
    input logic                           ack_i,
    input logic                           wr_en_i,
    input logic [ex_pkg::reg_addr_w-1:0]  wr_addr_i,
    input logic [ex_pkg::data_w-1:0]      wr_data_i,
    input logic                           overflow_i
);

    timeunit 1ns;
    timeprecision 1ps;

    // ack only answers a pending request
    ack_needs_req: assert property (
        @(posedge clk) disable iff (rst_i) $rose(ack_i) |-> req_i
    ) else $error("ack rose without a pending request");

    // outputs frozen until the request drops
    hold_while_req: assert property (
        @(posedge clk) disable iff (rst_i)
        (ack_i && req_i) |=> (ack_i && $stable(wr_en_i) && $stable(wr_addr_i)
                              && $stable(wr_data_i) && $stable(overflow_i))
    ) else $error("ack or outputs changed while the request was still high");

    // idle unit stays quiet from reset until a request
    quiet_until_req: assert property (
        @(posedge clk) (rst_i || (!req_i && !ack_i)) |=> !ack_i
    ) else $error("ack rose while no request was pending");

endmodule

bind ex_stage_top ex_stage_properties u_ex_stage_properties (
    .clk        (clk),
    .rst_i      (rst_i),
    .req_i      (req_i),
    .ack_i      (ack_o),
    .wr_en_i    (wr_en_o),
    .wr_addr_i  (wr_addr_o),
    .wr_data_i  (wr_data_o),
    .overflow_i (overflow_o)
);

/* verif/tb_ex_stage.sv */
module tb_ex_stage;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int    timeout_cycles = 100;
    localparam int    hold_cycles    = 2;
    localparam string stim_path      = "verif/ex_stim.txt";

    logic                            clk;
    logic                            rst;
    logic                            req;
    logic [ex_pkg::data_w-1:0]       instr;
    logic [ex_pkg::data_w-1:0]       rs_data;
    logic [ex_pkg::data_w-1:0]       rt_data;
    logic                            ack;
    logic                            wr_en;
    logic [ex_pkg::reg_addr_w-1:0]   wr_addr;
    logic [ex_pkg::data_w-1:0]       wr_data;
    logic                            overflow;

    int test_cnt;
    int fail_cnt;
    bit timed_out;

    ex_stage_top u_ex_stage_top (
        .clk        (clk),
        .rst_i      (rst),
        .req_i      (req),
        .instr_i    (instr),
        .rs_data_i  (rs_data),
        .rt_data_i  (rt_data),
        .ack_o      (ack),
        .wr_en_o    (wr_en),
        .wr_addr_o  (wr_addr),
        .wr_data_o  (wr_data),
        .overflow_o (overflow)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    // polled once per cycle, 5 ns after the edge
    task automatic wait_for_ack(input logic level, output bit ok);
        int cycles;
        ok = 1'b0;
        cycles = 0;
        while (!ok && cycles < timeout_cycles) begin
            @(posedge clk);
            #5;
            cycles = cycles + 1;
            if (ack === level) begin
                ok = 1'b1;
            end
        end
    endtask

    task automatic check_outputs(
        input  int                             num,
        input  logic                           exp_wr,
        input  logic [ex_pkg::reg_addr_w-1:0]  exp_addr,
        input  logic [ex_pkg::data_w-1:0]      exp_data,
        input  logic                           exp_ovf,
        output bit                             ok
    );
        ok = 1'b1;
        assert (wr_en === exp_wr) else begin
            $display("MISMATCH at %0t ns: test %0d wr_en_o %b, expected %b",
                     $time, num, wr_en, exp_wr);
            ok = 1'b0;
        end
        assert (overflow === exp_ovf) else begin
            $display("MISMATCH at %0t ns: test %0d overflow_o %b, expected %b",
                     $time, num, overflow, exp_ovf);
            ok = 1'b0;
        end
        // address and data are don't care without a write
        if (exp_wr) begin
            assert (wr_addr === exp_addr) else begin
                $display("MISMATCH at %0t ns: test %0d wr_addr_o %0d, expected %0d",
                         $time, num, wr_addr, exp_addr);
                ok = 1'b0;
            end
            assert (wr_data === exp_data) else begin
                $display("MISMATCH at %0t ns: test %0d wr_data_o %h, expected %h",
                         $time, num, wr_data, exp_data);
                ok = 1'b0;
            end
        end
    endtask

    task automatic run_op(
        input int                   num,
        input logic [31:0]          t_instr,
        input logic [31:0]          t_rs,
        input logic [31:0]          t_rt,
        input logic [31:0]          t_wr,
        input logic [31:0]          t_addr,
        input logic [31:0]          t_data,
        input logic [31:0]          t_ovf
    );
        bit ok;
        bit got;
        bit held;
        ok      = 1'b0;
        instr   = t_instr;
        rs_data = t_rs;
        rt_data = t_rt;
        req     = 1'b1;
        wait_for_ack(1'b1, got);
        if (!got) begin
            $display("test %0d: no acknowledge within %0d cycles of the request",
                     num, timeout_cycles);
            timed_out = 1'b1;
        end else begin
            check_outputs(num, t_wr[0], t_addr[4:0], t_data, t_ovf[0], ok);
            // request kept up, the answer must not move
            repeat (hold_cycles) begin
                @(posedge clk);
                #5;
            end
            assert (ack === 1'b1) else begin
                $display("MISMATCH at %0t ns: test %0d ack_o dropped while req_i was high",
                         $time, num);
                ok = 1'b0;
            end
            check_outputs(num, t_wr[0], t_addr[4:0], t_data, t_ovf[0], held);
            ok = ok && held;
            req = 1'b0;
            wait_for_ack(1'b0, got);
            if (!got) begin
                $display("test %0d: acknowledge still high %0d cycles after the request dropped",
                         num, timeout_cycles);
                timed_out = 1'b1;
                ok = 1'b0;
            end
        end
        if (ok) begin
            $display("test %0d instr %h: pass", num, t_instr);
        end else begin
            $display("test %0d instr %h: fail", num, t_instr);
            fail_cnt = fail_cnt + 1;
        end
    endtask

    initial begin
        int          fd;
        int          n;
        string       line;
        logic [31:0] f_instr;
        logic [31:0] f_rs;
        logic [31:0] f_rt;
        logic [31:0] f_wr;
        logic [31:0] f_addr;
        logic [31:0] f_data;
        logic [31:0] f_ovf;

        rst       = 1'b1;
        req       = 1'b0;
        instr     = '0;
        rs_data   = '0;
        rt_data   = '0;
        test_cnt  = 0;
        fail_cnt  = 0;
        timed_out = 1'b0;

        repeat (4) @(posedge clk);
        #5;
        rst = 1'b0;

        fd = $fopen(stim_path, "r");
        if (fd == 0) begin
            $display("could not open stimulus file %s", stim_path);
            fail_cnt = fail_cnt + 1;
        end else begin
            while (!timed_out && !$feof(fd)) begin
                n = $fgets(line, fd);
                // comment and blank lines do not scan
                if (n > 0 && $sscanf(line, "%h %h %h %h %h %h %h", f_instr, f_rs, f_rt,
                                     f_wr, f_addr, f_data, f_ovf) == 7) begin
                    test_cnt = test_cnt + 1;
                    run_op(test_cnt, f_instr, f_rs, f_rt, f_wr, f_addr, f_data, f_ovf);
                end
            end
            $fclose(fd);
        end

        $display("tests %0d, passed %0d, failed %0d", test_cnt, test_cnt - fail_cnt, fail_cnt);
        if (fail_cnt == 0 && test_cnt > 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

/* verif/ex_stim.txt */
# columns, all hex: instr rs_data rt_data exp_wr_en exp_addr exp_data exp_overflow
# exp_addr and exp_data are ignored where exp_wr_en is 0
00221820 00000005 00000007 1 03 0000000c 0
00222021 ffffffff 00000002 1 04 00000001 0
00222823 00000003 00000005 1 05 fffffffe 0
00223024 ff00ff00 0ff00ff0 1 06 0f000f00 0
00223825 ff00ff00 0ff00ff0 1 07 fff0fff0 0
00224026 ff00ff00 0ff00ff0 1 08 f0f0f0f0 0
00224827 ff00ff00 0ff00ff0 1 09 000f000f 0
0022502a fffffffe 00000001 1 0a 00000001 0
0022582b fffffffe 00000001 1 0b 00000000 0
202cfffe 00000010 00000000 1 0c 0000000e 0
282dffff 00000000 00000000 1 0d 00000000 0
302e8f0f ffffffff 00000000 1 0e 00008f0f 0
342f8001 12340000 00000000 1 0f 12348001 0
3830ffff aaaa5555 00000000 1 10 aaaaaaaa 0
3c31beef 00000000 00000000 1 11 beef0000 0
00229100 00000000 000000ff 1 12 00000ff0 0
00229a02 00000000 80000000 1 13 00800000 0
0022a203 00000000 80000000 1 14 ff800000 0
0022a804 00000023 00000001 1 15 00000008 0
0022b007 00000104 f0000000 1 16 ff000000 0
00221820 7fffffff 00000001 0 00 00000000 1
202cfffe 80000000 00000000 0 00 00000000 1
00221822 80000000 00000001 0 00 00000000 1
00222021 7fffffff 00000001 1 04 80000000 0
00220018 fffffffe 00000003 0 00 00000000 0
00002810 00000000 00000000 1 05 ffffffff 0
00003012 00000000 00000000 1 06 fffffffa 0
00220019 fffffffe 00000003 0 00 00000000 0
00002810 00000000 00000000 1 05 00000002 0
0022001a fffffff9 00000002 0 00 00000000 0
00003012 00000000 00000000 1 06 fffffffd 0
00002810 00000000 00000000 1 05 ffffffff 0
0022001b 00000064 00000007 0 00 00000000 0
00003012 00000000 00000000 1 06 0000000e 0
00002810 00000000 00000000 1 05 00000002 0
00200011 12345678 00000000 0 00 00000000 0
00200013 9abcdef0 00000000 0 00 00000000 0
00002810 00000000 00000000 1 05 12345678 0
00003012 00000000 00000000 1 06 9abcdef0 0

/* filelist.f */
logic/ex_pkg.sv
logic/ex_op_if.sv
logic/ex_res_if.sv
logic/ex_divider.sv
logic/ex_decode.sv
logic/ex_execute.sv
logic/ex_writeback.sv
logic/ex_stage_top.sv
verif/ex_stage_properties.sv
verif/tb_ex_stage.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run tb_ex_stage with Verilator, then judge the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module tb_ex_stage -f filelist.f -o tb_ex_stage \
    && ./obj_dir/tb_ex_stage > sim.log 2>&1 \
    || echo "build or simulation exited with an error" >> sim.log

cat sim.log
grep -q "TB FAILED" sim.log && { echo "simulation failed"; exit 1; }
grep -q "TB PASSED" sim.log && echo "simulation passed" && exit 0
echo "simulation did not finish"
exit 1
